// ==== zx_video_cfg.svh ====
// Timing and address constants for the ZX81 video pipeline
// Clock enable periods, line counts, sync and blank positions

`ifndef ZX_VIDEO_CFG_SVH
`define ZX_VIDEO_CFG_SVH

// ========================================
// Clock enable periods in clk_sys cycles
// ========================================
`define ZX_CE_CPU_DIV   16
`define ZX_CE_PIX_DIV   8
`define ZX_CE_SYNC_DIV  16

// Bus-side line counter
`define ZX_SYNC_LAST    206
`define ZX_HSYNC_ON     15
`define ZX_HSYNC_OFF    31

// ========================================
// Output line timing in pixel enables
// ========================================
`define ZX_DOT_LAST     413
`define ZX_HS_OUT_ON    0
`define ZX_HS_OUT_OFF   32
`define ZX_HBLANK_ON    400
`define ZX_HBLANK_OFF   72

// Vertical sync history depth
`define ZX_VREG_LEN     5

// CHROMA81 control port
`define ZX_PORT_CHROMA  16'h7FEF

`endif

// ==== zx_bus_pkg.sv ====
// Z80 bus types shared by the video stages

package zx_bus_pkg;

	// Full 16-bit address bus
	typedef logic [15:0] zx_addr_t;

	// Data bus byte, also used for character codes and attributes
	typedef logic [7:0] zx_byte_t;

endpackage

// ==== zx_video_pkg.sv ====
// Pixel, colour and character generator types

package zx_video_pkg;

	// One pixel colour in CHROMA81 order, intensity on top
	typedef struct packed {
		logic i;
		logic g;
		logic r;
		logic b;
	} rgbi_t;

	// CHROMA81 control register at port 7FEF
	typedef struct packed {
		logic [1:0] spare;
		logic       color_en;
		logic       attr_file;
		rgbi_t      border;
	} chroma_ctrl_t;

	// Character row within an 8-line cell
	typedef logic [2:0] row_t;

	// Character ROM address
	typedef logic [12:0] char_addr_t;

	// One output colour channel
	typedef logic [7:0] vga_chan_t;

endpackage

// ==== zx_clock_enables.sv ====
// Clock enable generator for CPU, pixel and sync timing

`timescale 1ns/1ps
`include "zx_video_cfg.svh"

module zx_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu,
	output logic ce_pix,
	output logic ce_sync
);

	// Decode masks, all periods divide the 32-count
	localparam logic [4:0] CPU_MASK  = 5'(`ZX_CE_CPU_DIV - 1);
	localparam logic [4:0] PIX_MASK  = 5'(`ZX_CE_PIX_DIV - 1);
	localparam logic [4:0] SYNC_MASK = 5'(`ZX_CE_SYNC_DIV - 1);

	logic [4:0] div_count;

	// Enables are registered so they come out glitch free
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_count <= '0;
			ce_cpu    <= 1'b0;
			ce_pix    <= 1'b0;
			ce_sync   <= 1'b0;
		end else begin
			div_count <= div_count + 5'd1;
			ce_cpu    <= (div_count & CPU_MASK) == 5'd0;
			ce_pix    <= (div_count & PIX_MASK) == 5'd0;
			ce_sync   <= (div_count & SYNC_MASK) == 5'd0;
		end
	end

endmodule

// ==== zx_sync_generator.sv ====
// ZX81 bus-side line sync counter, NMI latch and raw vertical sync

`timescale 1ns/1ps
`include "zx_video_cfg.svh"

module zx_sync_generator
	import zx_bus_pkg::*;
(
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     ce_sync,
	input  zx_addr_t addr,
	input  logic     m1,
	input  logic     iorq,
	input  logic     rd,
	input  logic     wr,
	output logic     line_sync,
	output logic     nmi_latch,
	output logic     nmi,
	output logic     vsync_raw
);

	localparam logic [7:0] SYNC_LAST = 8'(`ZX_SYNC_LAST);
	localparam logic [7:0] HSYNC_ON  = 8'(`ZX_HSYNC_ON);
	localparam logic [7:0] HSYNC_OFF = 8'(`ZX_HSYNC_OFF);

	logic [7:0] sync_count;
	logic       int_ack;
	logic       port_wr;
	logic       nmi_port_wr;
	logic       kbd_rd;

	assign int_ack     = m1 & iorq;
	assign port_wr     = iorq & wr;
	assign nmi_port_wr = port_wr & (addr[0] ^ addr[1]);
	// Keyboard port is any even I/O read
	assign kbd_rd      = iorq & rd & ~addr[0];

	// ========================================
	// Line counter
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset || int_ack) begin
			sync_count <= '0;
			line_sync  <= 1'b0;
		end else if (ce_sync) begin
			if (sync_count == SYNC_LAST) begin
				sync_count <= '0;
			end else begin
				sync_count <= sync_count + 8'd1;
			end
			if (sync_count == HSYNC_ON) begin
				line_sync <= 1'b1;
			end else if (sync_count == HSYNC_OFF) begin
				line_sync <= 1'b0;
			end
		end
	end

	// FE turns the NMI on, FD turns it off
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi_latch <= 1'b0;
		end else if (nmi_port_wr) begin
			nmi_latch <= addr[1];
		end
	end

	assign nmi = nmi_latch & line_sync;

	// Raw vsync only moves in fast mode
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vsync_raw <= 1'b0;
		end else if (!nmi_latch) begin
			if (kbd_rd) begin
				vsync_raw <= 1'b1;
			end else if (port_wr) begin
				vsync_raw <= 1'b0;
			end
		end
	end

endmodule

// ==== zx_char_shifter.sv ====
// Character code latch, NOP generator test, row counter
// and the 8-dot shift register with its paper mask

`timescale 1ns/1ps

module zx_char_shifter
	import zx_bus_pkg::*;
	import zx_video_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       ce_cpu,
	input  logic       ce_pix,
	input  zx_addr_t   addr,
	input  zx_byte_t   mem_data,
	input  zx_byte_t   attr_data,
	input  logic       m1,
	input  logic       mreq,
	input  logic       rfsh,
	input  logic       halt,
	input  logic       line_sync,
	input  logic       vsync_raw,
	input  logic       nmi_latch,
	input  logic       hblank,
	output logic       dot,
	output logic       border,
	output logic       inverse,
	output zx_byte_t   attr,
	output char_addr_t char_addr
);

	zx_byte_t   data_latch;
	logic [7:0] shift_reg;
	logic [7:0] paper_reg;
	row_t       row_count;
	logic       nop_store;
	logic       shifter_en;
	logic       start_d;
	logic       line_sync_d;
	logic       hblank_d;
	logic       nopgen;
	logic       latch_en;
	logic       shifter_start;
	logic       load;

	// Upper-half fetch with bit 6 clear is forced to a NOP
	assign nopgen        = addr[15] & ~mem_data[6] & ~halt;
	assign latch_en      = ~rfsh & ce_cpu & mreq;
	assign shifter_start = ~mreq & nop_store & ce_cpu & shifter_en & ~nmi_latch;
	assign load          = ce_pix & shifter_start & ~start_d;

	// Code and attribute bytes
	always_ff @(posedge clk_sys) begin
		if (ce_pix && latch_en) begin
			data_latch <= mem_data;
		end
		if (load) begin
			attr <= attr_data;
		end
	end

	// ========================================
	// Shifter, row count and enable
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nop_store   <= 1'b0;
			start_d     <= 1'b0;
			shift_reg   <= '0;
			paper_reg   <= '0;
			inverse     <= 1'b0;
			row_count   <= '0;
			line_sync_d <= 1'b0;
			hblank_d    <= 1'b0;
			shifter_en  <= 1'b1;
		end else if (ce_pix) begin
			if (latch_en) begin
				nop_store <= nopgen;
			end
			start_d <= shifter_start;
			if (~mreq & ce_cpu) begin
				inverse <= 1'b0;
			end

			if (load) begin
				shift_reg <= (m1 & nopgen) ? 8'h00 : mem_data;
				paper_reg <= 8'hFF;
				inverse   <= data_latch[7];
			end else begin
				shift_reg <= {shift_reg[6:0], 1'b0};
				paper_reg <= {paper_reg[6:0], 1'b0};
			end

			// Row advances per bus line, vsync restarts the cell
			line_sync_d <= line_sync;
			if (vsync_raw) begin
				row_count <= '0;
			end else if (line_sync && !line_sync_d) begin
				row_count <= row_count + 3'd1;
			end

			// Suppress garbage loads during blanking
			hblank_d <= hblank;
			if (hblank && !hblank_d) begin
				shifter_en <= 1'b0;
			end else if (!hblank && hblank_d) begin
				shifter_en <= 1'b1;
			end
		end
	end

	assign dot    = shift_reg[7];
	assign border = ~paper_reg[7];

	// ROM sees the character pattern address during refresh
	assign char_addr = rfsh ? {addr[12:9], data_latch[5:0], row_count} : addr[12:0];

endmodule

// ==== zx_color_mapper.sv ====
// CHROMA81 control register and dot to RGB conversion

`timescale 1ns/1ps
`include "zx_video_cfg.svh"

module zx_color_mapper
	import zx_bus_pkg::*;
	import zx_video_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  zx_addr_t  addr,
	input  zx_byte_t  cpu_data,
	input  logic      iorq,
	input  logic      wr,
	input  logic      dot,
	input  logic      border,
	input  logic      inverse,
	input  zx_byte_t  attr,
	input  logic      invert_video,
	input  logic      black_border,
	output vga_chan_t red,
	output vga_chan_t green,
	output vga_chan_t blue
);

	localparam zx_addr_t PORT_CHROMA = `ZX_PORT_CHROMA;

	chroma_ctrl_t chroma;
	rgbi_t        pix;
	logic         chroma_wr;
	logic         video_bit;

	// Colour bit on top, bright copies below
	function automatic vga_chan_t expand_chan(input logic c, input logic i);
		return {c, {3{c & i}}, c, {3{c & i}}};
	endfunction

	assign chroma_wr = iorq & wr & (addr == PORT_CHROMA);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			chroma <= '0;
		end else if (chroma_wr) begin
			chroma <= chroma_ctrl_t'(cpu_data);
		end
	end

	// Normal video shows a set dot as black
	assign video_bit = dot ^ inverse ^ ~invert_video;

	always_comb begin
		if (black_border && border) begin
			pix = '0;
		end else if (!chroma.color_en) begin
			pix = rgbi_t'({4{video_bit}});
		end else if (border) begin
			pix = chroma.border;
		end else if (video_bit) begin
			pix = rgbi_t'(attr[7:4]);
		end else begin
			pix = rgbi_t'(attr[3:0]);
		end
	end

	assign red   = expand_chan(pix.r, pix.i);
	assign green = expand_chan(pix.g, pix.i);
	assign blue  = expand_chan(pix.b, pix.i);

endmodule

// ==== zx_display_timing.sv ====
// Output line timing with fixed blanking and filtered vertical sync

`timescale 1ns/1ps
`include "zx_video_cfg.svh"

module zx_display_timing (
	input  logic clk_sys,
	input  logic reset,
	input  logic ce_pix,
	input  logic line_sync,
	input  logic vsync_raw,
	output logic hsync_out,
	output logic vsync_out,
	output logic hblank,
	output logic vblank
);

	localparam logic [8:0] DOT_LAST    = 9'(`ZX_DOT_LAST);
	localparam logic [8:0] HS_ON       = 9'(`ZX_HS_OUT_ON);
	localparam logic [8:0] HS_OFF      = 9'(`ZX_HS_OUT_OFF);
	localparam logic [8:0] HBLANK_ON   = 9'(`ZX_HBLANK_ON);
	localparam logic [8:0] HBLANK_OFF  = 9'(`ZX_HBLANK_OFF);

	logic [8:0]              dot_count;
	logic [`ZX_VREG_LEN-1:0] vreg;
	logic                    line_sync_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dot_count   <= '0;
			hsync_out   <= 1'b0;
			hblank      <= 1'b0;
			vblank      <= 1'b0;
			vsync_out   <= 1'b0;
			vreg        <= '0;
			line_sync_d <= 1'b0;
		end else if (ce_pix) begin
			// ========================================
			// Free-running 414-dot line
			// ========================================
			if (dot_count == DOT_LAST) begin
				dot_count <= '0;
			end else begin
				dot_count <= dot_count + 9'd1;
			end

			if (dot_count == HS_ON) begin
				hsync_out <= 1'b1;
			end else if (dot_count == HS_OFF) begin
				hsync_out <= 1'b0;
			end

			if (dot_count == HBLANK_ON) begin
				hblank <= 1'b1;
			end else if (dot_count == HBLANK_OFF) begin
				hblank <= 1'b0;
			end

			// Vertical history sampled once per bus line
			line_sync_d <= line_sync;
			if (line_sync && !line_sync_d) begin
				vreg      <= {vreg[`ZX_VREG_LEN-2:0], vsync_raw};
				vblank    <= |{vreg, vsync_raw};
				vsync_out <= vreg[2];
				// Lock the line phase at frame start
				if (vreg[3] && vreg[2]) begin
					dot_count <= '0;
				end
			end
		end
	end

endmodule

// ==== zx_video_top.sv ====
// ZX81 video pipeline top level
// Clock enables, bus sync, character shifter, colour and output timing

`timescale 1ns/1ps

module zx_video_top
	import zx_bus_pkg::*;
	import zx_video_pkg::*;
(
	input  logic       clk_sys,
	input  logic       reset,
	// Z80 bus as seen by the video logic
	input  zx_addr_t   addr,
	input  zx_byte_t   mem_data,
	input  zx_byte_t   attr_data,
	input  zx_byte_t   cpu_data,
	input  logic       m1,
	input  logic       mreq,
	input  logic       iorq,
	input  logic       rd,
	input  logic       wr,
	input  logic       rfsh,
	input  logic       halt,
	// Display options
	input  logic       invert_video,
	input  logic       black_border,
	output logic       pixel_ce,
	output logic       cpu_ce,
	output vga_chan_t  red,
	output vga_chan_t  green,
	output vga_chan_t  blue,
	output logic       hsync_out,
	output logic       vsync_out,
	output logic       hblank,
	output logic       vblank,
	output logic       nmi,
	output char_addr_t char_addr
);

	logic     ce_cpu;
	logic     ce_pix;
	logic     ce_sync;
	logic     line_sync;
	logic     nmi_latch;
	logic     vsync_raw;
	logic     dot;
	logic     border;
	logic     inverse;
	zx_byte_t attr;

	assign pixel_ce = ce_pix;
	assign cpu_ce   = ce_cpu;

	zx_clock_enables zx_clock_enables_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_cpu  (ce_cpu),
		.ce_pix  (ce_pix),
		.ce_sync (ce_sync)
	);

	zx_sync_generator zx_sync_generator_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_sync   (ce_sync),
		.addr      (addr),
		.m1        (m1),
		.iorq      (iorq),
		.rd        (rd),
		.wr        (wr),
		.line_sync (line_sync),
		.nmi_latch (nmi_latch),
		.nmi       (nmi),
		.vsync_raw (vsync_raw)
	);

	zx_char_shifter zx_char_shifter_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_cpu    (ce_cpu),
		.ce_pix    (ce_pix),
		.addr      (addr),
		.mem_data  (mem_data),
		.attr_data (attr_data),
		.m1        (m1),
		.mreq      (mreq),
		.rfsh      (rfsh),
		.halt      (halt),
		.line_sync (line_sync),
		.vsync_raw (vsync_raw),
		.nmi_latch (nmi_latch),
		.hblank    (hblank),
		.dot       (dot),
		.border    (border),
		.inverse   (inverse),
		.attr      (attr),
		.char_addr (char_addr)
	);

	zx_color_mapper zx_color_mapper_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.cpu_data     (cpu_data),
		.iorq         (iorq),
		.wr           (wr),
		.dot          (dot),
		.border       (border),
		.inverse      (inverse),
		.attr         (attr),
		.invert_video (invert_video),
		.black_border (black_border),
		.red          (red),
		.green        (green),
		.blue         (blue)
	);

	zx_display_timing zx_display_timing_inst (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_pix    (ce_pix),
		.line_sync (line_sync),
		.vsync_raw (vsync_raw),
		.hsync_out (hsync_out),
		.vsync_out (vsync_out),
		.hblank    (hblank),
		.vblank    (vblank)
	);

endmodule

// ==== tb_zx_bus_tasks.svh ====
// Z80 bus cycle tasks for the video testbench
// I/O write and read, interrupt acknowledge and character fetch

`ifndef TB_ZX_BUS_TASKS_SVH
`define TB_ZX_BUS_TASKS_SVH

// Bus changes a fixed delay after the rising edge
task automatic next_drive_slot;
	@(posedge clk_sys);
	#5;
endtask

task automatic bus_idle;
	addr      = 16'h0000;
	mem_data  = 8'h00;
	attr_data = 8'h00;
	cpu_data  = 8'h00;
	m1        = 1'b0;
	mreq      = 1'b0;
	iorq      = 1'b0;
	rd        = 1'b0;
	wr        = 1'b0;
	rfsh      = 1'b0;
	halt      = 1'b0;
endtask

// Keep the bus as it is through the next cpu_ce
task automatic hold_until_cpu_ce;
	int waited;
	waited = 0;
	@(negedge clk_sys);
	while (!cpu_ce) begin
		waited++;
		if (waited > 2 * `ZX_CE_CPU_DIV) begin
			fail_test("cpu_ce stopped pulsing during a bus cycle");
		end
		@(negedge clk_sys);
	end
	next_drive_slot();
endtask

task automatic io_write(input zx_addr_t port, input zx_byte_t value);
	next_drive_slot();
	addr     = port;
	cpu_data = value;
	iorq     = 1'b1;
	wr       = 1'b1;
	hold_until_cpu_ce();
	bus_idle();
endtask

task automatic io_read(input zx_addr_t port);
	next_drive_slot();
	addr = port;
	iorq = 1'b1;
	rd   = 1'b1;
	hold_until_cpu_ce();
	bus_idle();
endtask

task automatic int_ack;
	next_drive_slot();
	m1   = 1'b1;
	iorq = 1'b1;
	hold_until_cpu_ce();
	bus_idle();
endtask

task automatic char_fetch(input zx_byte_t code, input zx_byte_t pattern,
		input zx_byte_t attribute);
	// Opcode fetch from the display file mirror above 8000h
	next_drive_slot();
	addr     = {8'hC0, code};
	m1       = 1'b1;
	mreq     = 1'b1;
	mem_data = code;
	hold_until_cpu_ce();
	// Refresh, pattern byte from the character ROM
	m1        = 1'b0;
	mreq      = 1'b0;
	rfsh      = 1'b1;
	addr      = 16'h1E00;
	mem_data  = pattern;
	attr_data = attribute;
	// ROM address carries the fetched code during refresh
	@(negedge clk_sys);
	check_value("char_addr[8:3]", char_addr[8:3], code[5:0]);
	hold_until_cpu_ce();
	// Plain read below 8000h drops the NOP flag
	rfsh     = 1'b0;
	mreq     = 1'b1;
	addr     = 16'h4000;
	mem_data = 8'h00;
	hold_until_cpu_ce();
	bus_idle();
endtask

`endif

// ==== tb_zx_video.sv ====
// Testbench for the ZX81 video pipeline
// Clock, reset, DUT, checks and the test sequence

`timescale 1ns/1ps
`include "zx_video_cfg.svh"

module tb_zx_video
	import zx_bus_pkg::*;
	import zx_video_pkg::*;
();

	localparam int LINE_PIXELS = `ZX_DOT_LAST + 1;
	localparam int LINE_CLOCKS = LINE_PIXELS * `ZX_CE_PIX_DIV;
	localparam int HS_PIXELS   = `ZX_HS_OUT_OFF - `ZX_HS_OUT_ON;

	logic       clk_sys;
	logic       reset;
	zx_addr_t   addr;
	zx_byte_t   mem_data;
	zx_byte_t   attr_data;
	zx_byte_t   cpu_data;
	logic       m1;
	logic       mreq;
	logic       iorq;
	logic       rd;
	logic       wr;
	logic       rfsh;
	logic       halt;
	logic       invert_video;
	logic       black_border;
	logic       pixel_ce;
	logic       cpu_ce;
	vga_chan_t  red;
	vga_chan_t  green;
	vga_chan_t  blue;
	logic       hsync_out;
	logic       vsync_out;
	logic       hblank;
	logic       vblank;
	logic       nmi;
	char_addr_t char_addr;
	integer     seed;

	zx_video_top zx_video_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.mem_data     (mem_data),
		.attr_data    (attr_data),
		.cpu_data     (cpu_data),
		.m1           (m1),
		.mreq         (mreq),
		.iorq         (iorq),
		.rd           (rd),
		.wr           (wr),
		.rfsh         (rfsh),
		.halt         (halt),
		.invert_video (invert_video),
		.black_border (black_border),
		.pixel_ce     (pixel_ce),
		.cpu_ce       (cpu_ce),
		.red          (red),
		.green        (green),
		.blue         (blue),
		.hsync_out    (hsync_out),
		.vsync_out    (vsync_out),
		.hblank       (hblank),
		.vblank       (vblank),
		.nmi          (nmi),
		.char_addr    (char_addr)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	// ========================================
	// Error handling and checks
	// ========================================
	task automatic abort_run;
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped after an error");
	endtask

	task automatic fail_test(input string reason);
		$display("ERROR: %s", reason);
		abort_run();
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		assert (actual === expected) else begin
			$display("CHECK FAILED: %s is 0x%0h, expected 0x%0h", name, actual, expected);
			abort_run();
		end
	endtask

	// Colour bit on top of each nibble, low bits lit by intensity
	function automatic vga_chan_t expected_channel(input logic colour, input logic bright);
		logic [3:0] nibble;
		nibble = {colour, {3{colour & bright}}};
		return {nibble, nibble};
	endfunction

	function automatic logic shows_colour(input logic [3:0] rgbi);
		return red == expected_channel(rgbi[1], rgbi[3])
			&& green == expected_channel(rgbi[2], rgbi[3])
			&& blue == expected_channel(rgbi[0], rgbi[3]);
	endfunction

	task automatic check_colour(input logic [3:0] rgbi);
		check_value("red", red, expected_channel(rgbi[1], rgbi[3]));
		check_value("green", green, expected_channel(rgbi[2], rgbi[3]));
		check_value("blue", blue, expected_channel(rgbi[0], rgbi[3]));
	endtask

	// vblank must cover the whole vertical sync pulse
	always @(negedge clk_sys) begin
		if (!reset && vsync_out) begin
			check_value("vblank", vblank, 1'b1);
		end
	end

	`include "tb_zx_bus_tasks.svh"

	// ========================================
	// Waits, each with its own limit
	// ========================================
	task automatic next_pixel;
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!pixel_ce) begin
			waited++;
			if (waited > 2 * `ZX_CE_PIX_DIV) begin
				fail_test("pixel_ce stopped pulsing");
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic check_line_timing;
		int   count;
		int   high_count;
		logic last_hs;
		count = 0;
		@(negedge clk_sys);
		last_hs = hsync_out;
		@(negedge clk_sys);
		while (!(hsync_out && !last_hs)) begin
			last_hs = hsync_out;
			count++;
			if (count > 2 * LINE_CLOCKS) begin
				fail_test("hsync_out never rose");
			end
			@(negedge clk_sys);
		end
		// Each pulse counted after its register update is visible
		count = 0;
		while (hsync_out) begin
			next_pixel();
			count++;
			if (count > LINE_PIXELS) begin
				fail_test("hsync_out stayed high for a whole line");
			end
			@(negedge clk_sys);
		end
		high_count = count;
		while (!hsync_out) begin
			next_pixel();
			count++;
			if (count > LINE_PIXELS + 8) begin
				fail_test("hsync_out did not rise again within a line");
			end
			@(negedge clk_sys);
		end
		check_value("hsync_out high pixels", high_count, HS_PIXELS);
		check_value("hsync_out period pixels", count, LINE_PIXELS);
	endtask

	task automatic wait_for_nmi(input int max_clocks);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!nmi) begin
			waited++;
			if (waited > max_clocks) begin
				fail_test("nmi did not pulse within one output line");
			end
			@(negedge clk_sys);
		end
	endtask

	task automatic hold_nmi_low(input int lines);
		int n;
		for (n = 0; n < lines * LINE_CLOCKS; n++) begin
			@(negedge clk_sys);
			check_value("nmi", nmi, 1'b0);
		end
	endtask

	task automatic wait_for_vsync(input logic level, input int max_lines);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (vsync_out !== level) begin
			waited++;
			if (waited > max_lines * LINE_CLOCKS) begin
				fail_test($sformatf("vsync_out did not reach %0d within %0d lines",
					level, max_lines));
			end
			@(negedge clk_sys);
		end
	endtask

	// Returns just after hblank has fallen
	task automatic wait_hblank_end;
		int waited;
		waited = 0;
		@(negedge clk_sys);
		while (!hblank) begin
			waited++;
			if (waited > 2 * LINE_CLOCKS) begin
				fail_test("hblank never went high");
			end
			@(negedge clk_sys);
		end
		while (hblank) begin
			waited++;
			if (waited > 4 * LINE_CLOCKS) begin
				fail_test("hblank never went low again");
			end
			@(negedge clk_sys);
		end
	endtask

	// First dot of each pattern is set, so it marks the start
	task automatic watch_dots(input zx_byte_t pattern, input logic [3:0] ink,
			input logic [3:0] paper, input logic [3:0] background);
		int waited;
		int i;
		waited = 0;
		next_pixel();
		while (shows_colour(background)) begin
			waited++;
			if (waited > 32) begin
				fail_test("character dots never appeared after the fetch");
			end
			next_pixel();
		end
		for (i = 7; i >= 0; i--) begin
			if (pattern[i]) begin
				check_colour(ink);
			end else begin
				check_colour(paper);
			end
			if (i > 0) begin
				next_pixel();
			end
		end
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		zx_byte_t code;
		zx_byte_t pattern;
		zx_byte_t attr_byte;
		zx_byte_t chroma_byte;
		seed         = 32'ha7e3c9c5;
		reset        = 1'b1;
		invert_video = 1'b0;
		black_border = 1'b0;
		bus_idle();
		repeat (2) @(posedge clk_sys);
		#5 reset = 1'b0;

		@(negedge clk_sys);
		check_value("nmi", nmi, 1'b0);
		check_value("vsync_out", vsync_out, 1'b0);
		check_value("hsync_out", hsync_out, 1'b0);

		check_line_timing();

		// FE switches NMI on, FD off
		io_write(16'h00FE, 8'h00);
		wait_for_nmi(LINE_CLOCKS + 16);
		io_write(16'h00FD, 8'h00);
		hold_nmi_low(2);

		// Restart the bus line, then a keyboard read starts vsync
		int_ack();
		io_read(16'h00FE);
		wait_for_vsync(1'b1, 5);
		io_write(16'h00FF, 8'h00);
		wait_for_vsync(1'b0, 6);

		// Black and white, normal then inverted
		code    = zx_byte_t'($random(seed)) & 8'h3F;
		pattern = zx_byte_t'($random(seed)) | 8'h80;
		wait_hblank_end();
		fork
			char_fetch(code, pattern, 8'h00);
			watch_dots(pattern, 4'h0, 4'hF, 4'hF);
		join
		@(posedge clk_sys);
		#5 invert_video = 1'b1;
		code    = zx_byte_t'($random(seed)) & 8'h3F;
		pattern = zx_byte_t'($random(seed)) | 8'h80;
		wait_hblank_end();
		fork
			char_fetch(code, pattern, 8'h00);
			watch_dots(pattern, 4'hF, 4'h0, 4'h0);
		join
		@(posedge clk_sys);
		#5 invert_video = 1'b0;

		// CHROMA81 border and attribute colours
		chroma_byte = zx_byte_t'($random(seed)) | 8'h20;
		io_write(`ZX_PORT_CHROMA, chroma_byte);
		next_pixel();
		check_colour(chroma_byte[3:0]);
		attr_byte = zx_byte_t'($random(seed));
		attr_byte[3:0] = chroma_byte[3:0] ^ 4'hF;
		code      = zx_byte_t'($random(seed)) & 8'h3F;
		pattern   = zx_byte_t'($random(seed)) | 8'h80;
		wait_hblank_end();
		fork
			char_fetch(code, pattern, attr_byte);
			watch_dots(pattern, attr_byte[3:0], attr_byte[7:4], chroma_byte[3:0]);
		join
		@(posedge clk_sys);
		#5 black_border = 1'b1;
		next_pixel();
		check_colour(4'h0);

		$display("TEST PASS");
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+.
zx_bus_pkg.sv
zx_video_pkg.sv
zx_clock_enables.sv
zx_sync_generator.sv
zx_char_shifter.sv
zx_color_mapper.sv
zx_display_timing.sv
zx_video_top.sv
tb_zx_video.sv
